// File: hw/gcm_pkg.sv
`default_nettype none

package gcm_pkg;

    // Cipher and GHASH block width.
    localparam int unsigned BLOCK_W = 128;

    // IV width for the 96-bit fast path of J0.
    localparam int unsigned IV_W = 96;

    localparam int unsigned LEN_W = 64;  // One bit-length field.
    localparam int unsigned CTR_W = 32;  // Low word stepped by inc32.

    // Bit 0 is the most significant bit and the x^0 coefficient.
    typedef logic [0:BLOCK_W-1] block_t;
    typedef logic [0:IV_W-1]    iv_t;
    typedef logic [0:LEN_W-1]   len_t;

    // Reduction constant R = 11100001 || 0^120.
    localparam block_t GF_R = {8'he1, {(BLOCK_W - 8){1'b0}}};

endpackage

`default_nettype wire

// File: hw/gf128_mul.sv
`timescale 1ns/1ps
`default_nettype none

module gf128_mul
(
    input  gcm_pkg::block_t i_a,
    input  gcm_pkg::block_t i_b,
    output gcm_pkg::block_t o_p
);

    gcm_pkg::block_t w_z;
    gcm_pkg::block_t w_v;

    // Shift-and-add over all 128 coefficients of i_a.
    // A right shift in this bit order multiplies V by x.
    always_comb
    begin
        w_z = '0;
        w_v = i_b;
        for (int i = 0; i < gcm_pkg::BLOCK_W; i++)
        begin
            if (i_a[i])
            begin
                w_z = w_z ^ w_v;
            end
            if (w_v[gcm_pkg::BLOCK_W-1])
            begin
                w_v = (w_v >> 1) ^ gcm_pkg::GF_R;  // x^128 folds back.
            end
            else
            begin
                w_v = w_v >> 1;
            end
        end
    end

    assign o_p = w_z;

endmodule

`default_nettype wire

// File: hw/gcm_block_seq.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_block_seq
#(
    parameter int CNT_W = 16
)
(
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_new_instance,
    input  gcm_pkg::len_t   i_aad_size,
    input  gcm_pkg::len_t   i_pt_size,
    input  logic            i_blk_valid,
    output logic            o_is_text,
    output logic            o_last,
    output gcm_pkg::block_t o_len_block
);

    localparam int BLK_SHIFT = $clog2(gcm_pkg::BLOCK_W);  // Bits to blocks.

    gcm_pkg::len_t    r_aad_size;
    gcm_pkg::len_t    r_pt_size;
    logic [CNT_W-1:0] r_count;
    logic             r_open;
    logic [CNT_W-1:0] w_aad_blks;
    logic [CNT_W-1:0] w_total_blks;

    // Sizes hold until the next instance for the length block.
    always_ff @(posedge clk)
    begin
        if (i_new_instance)
        begin
            r_aad_size <= i_aad_size;
            r_pt_size  <= i_pt_size;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_count <= '0;
            r_open  <= 1'b0;
        end
        else if (i_new_instance)
        begin
            r_count <= '0;
            r_open  <= 1'b1;
        end
        else if (i_blk_valid && r_open)
        begin
            r_count <= r_count + CNT_W'(1);
            if (o_last)
            begin
                r_open <= 1'b0;  // Instance fully received.
            end
        end
    end

    assign w_aad_blks   = CNT_W'(r_aad_size >> BLK_SHIFT);
    assign w_total_blks = w_aad_blks + CNT_W'(r_pt_size >> BLK_SHIFT);

    // All AAD first, then text.
    assign o_is_text   = (r_count >= w_aad_blks);
    assign o_last      = (r_count == w_total_blks - CNT_W'(1));
    assign o_len_block = {r_aad_size, r_pt_size};  // len(A) || len(C).

    a_blk_in_instance : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_blk_valid |-> r_open);

    a_blk_in_range : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_blk_valid |-> (r_count < w_total_blks));

endmodule

`default_nettype wire

// File: hw/gctr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module gctr_unit
(
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_new_instance,
    input  gcm_pkg::iv_t    i_iv,
    input  logic            i_blk_valid,
    input  gcm_pkg::block_t i_blk_data,
    input  gcm_pkg::block_t i_keystream,
    input  logic            i_is_text,
    input  logic            i_last,
    output gcm_pkg::block_t o_cb,
    output logic            o_ct_valid,
    output gcm_pkg::block_t o_cipher_text,
    output logic            o_auth_valid,
    output gcm_pkg::block_t o_auth_blk,
    output logic            o_auth_last
);

    localparam int HI_W = gcm_pkg::BLOCK_W - gcm_pkg::CTR_W;

    gcm_pkg::block_t r_cb;
    gcm_pkg::block_t w_cb_next;
    gcm_pkg::block_t w_cipher_text;

    assign w_cipher_text = i_blk_data ^ i_keystream;

    // inc32 keeps the upper 96 bits and wraps the low word.
    assign w_cb_next = {r_cb[0:HI_W-1],
                        r_cb[HI_W:gcm_pkg::BLOCK_W-1] + gcm_pkg::CTR_W'(1)};

    always_ff @(posedge clk)
    begin
        if (i_new_instance)
        begin
            r_cb <= {i_iv, gcm_pkg::CTR_W'(2)};  // J0 + 1, the first text counter.
        end
        else if (i_blk_valid && i_is_text)
        begin
            r_cb <= w_cb_next;
        end

        if (i_blk_valid)
        begin
            // GHASH takes AAD as is and text after encryption.
            o_auth_blk <= i_is_text ? w_cipher_text : i_blk_data;
            if (i_is_text)
            begin
                o_cipher_text <= w_cipher_text;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_ct_valid   <= 1'b0;
            o_auth_valid <= 1'b0;
            o_auth_last  <= 1'b0;
        end
        else
        begin
            o_ct_valid   <= i_blk_valid && i_is_text;
            o_auth_valid <= i_blk_valid;
            o_auth_last  <= i_blk_valid && i_last;
        end
    end

    assign o_cb = r_cb;  // Seen by the external cipher.

    a_no_blk_on_start : assert property (@(posedge clk) disable iff (!i_arst_n)
        i_new_instance |-> !i_blk_valid);

endmodule

`default_nettype wire

// File: hw/ghash_accum.sv
`timescale 1ns/1ps
`default_nettype none

module ghash_accum
(
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_new_instance,
    input  gcm_pkg::block_t i_h,
    input  gcm_pkg::block_t i_ek_j0,
    input  logic            i_auth_valid,
    input  gcm_pkg::block_t i_auth_blk,
    input  logic            i_auth_last,
    input  gcm_pkg::block_t i_len_block,
    output gcm_pkg::block_t o_tag,
    output logic            o_tag_ready
);

    gcm_pkg::block_t r_h;
    gcm_pkg::block_t r_ek_j0;
    gcm_pkg::block_t r_s;
    logic            r_len_pending;
    gcm_pkg::block_t w_mul_in;
    gcm_pkg::block_t w_prod;

    // Length block goes in right after the last auth block.
    assign w_mul_in = r_s ^ (r_len_pending ? i_len_block : i_auth_blk);

    gf128_mul gf128_mul_inst
    (
        .i_a (w_mul_in),
        .i_b (r_h),
        .o_p (w_prod)
    );

    always_ff @(posedge clk)
    begin
        if (i_new_instance)
        begin
            r_h     <= i_h;
            r_ek_j0 <= i_ek_j0;
            r_s     <= '0;
        end
        else if (i_auth_valid || r_len_pending)
        begin
            r_s <= w_prod;  // S = (S ^ X) * H.
        end

        if (r_len_pending)
        begin
            o_tag <= w_prod ^ r_ek_j0;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_len_pending <= 1'b0;
            o_tag_ready   <= 1'b0;
        end
        else
        begin
            r_len_pending <= i_auth_valid && i_auth_last;
            o_tag_ready   <= r_len_pending;  // One-cycle pulse with o_tag.
        end
    end

    // The multiplier is busy with the length block in that cycle.
    a_len_cycle_free : assert property (@(posedge clk) disable iff (!i_arst_n)
        r_len_pending |-> !i_auth_valid);

endmodule

`default_nettype wire

// File: hw/gcm_core.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_core
#(
    parameter int CNT_W = 16
)
(
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_new_instance,
    input  gcm_pkg::iv_t    i_iv,
    input  gcm_pkg::block_t i_h,
    input  gcm_pkg::block_t i_ek_j0,
    input  gcm_pkg::len_t   i_aad_size,
    input  gcm_pkg::len_t   i_pt_size,
    input  logic            i_blk_valid,
    input  gcm_pkg::block_t i_blk_data,
    input  gcm_pkg::block_t i_keystream,
    output gcm_pkg::block_t o_cb,
    output logic            o_ct_valid,
    output gcm_pkg::block_t o_cipher_text,
    output gcm_pkg::block_t o_tag,
    output logic            o_tag_ready
);

    logic            w_is_text;
    logic            w_last;
    gcm_pkg::block_t w_len_block;
    logic            w_auth_valid;
    gcm_pkg::block_t w_auth_blk;
    logic            w_auth_last;

    // Block classification, same cycle as i_blk_valid.
    gcm_block_seq
    #(
        .CNT_W (CNT_W)
    )
    gcm_block_seq_inst
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_new_instance (i_new_instance),
        .i_aad_size     (i_aad_size),
        .i_pt_size      (i_pt_size),
        .i_blk_valid    (i_blk_valid),
        .o_is_text      (w_is_text),
        .o_last         (w_last),
        .o_len_block    (w_len_block)
    );

    gctr_unit gctr_unit_inst
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_new_instance (i_new_instance),
        .i_iv           (i_iv),
        .i_blk_valid    (i_blk_valid),
        .i_blk_data     (i_blk_data),
        .i_keystream    (i_keystream),
        .i_is_text      (w_is_text),
        .i_last         (w_last),
        .o_cb           (o_cb),
        .o_ct_valid     (o_ct_valid),
        .o_cipher_text  (o_cipher_text),
        .o_auth_valid   (w_auth_valid),
        .o_auth_blk     (w_auth_blk),
        .o_auth_last    (w_auth_last)
    );

    // Tag lands two cycles after the last block.
    ghash_accum ghash_accum_inst
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_new_instance (i_new_instance),
        .i_h            (i_h),
        .i_ek_j0        (i_ek_j0),
        .i_auth_valid   (w_auth_valid),
        .i_auth_blk     (w_auth_blk),
        .i_auth_last    (w_auth_last),
        .i_len_block    (w_len_block),
        .o_tag          (o_tag),
        .o_tag_ready    (o_tag_ready)
    );

endmodule

`default_nettype wire

// File: tb/gcm_ref.svh
`ifndef GCM_REF_SVH
`define GCM_REF_SVH

// Product in GF(2^128) by walking the bits of y and shifting x.
function automatic gcm_pkg::block_t ref_gf_mul(input gcm_pkg::block_t x,
                                               input gcm_pkg::block_t y);
    gcm_pkg::block_t z;
    gcm_pkg::block_t v;
    logic            carry;
    z = '0;
    v = x;
    for (int i = 0; i < 128; i++)
    begin
        if (y[i])
        begin
            z = z ^ v;
        end
        carry = v[127];
        v = v >> 1;
        if (carry)
        begin
            v[0:7] = v[0:7] ^ 8'he1;  // Reduce by x^128 + x^7 + x^2 + x + 1.
        end
    end
    return z;
endfunction

// Steps the low 32 bits and keeps the rest.
function automatic gcm_pkg::block_t ref_inc32(input gcm_pkg::block_t cb);
    ref_inc32 = cb;
    ref_inc32[96:127] = cb[96:127] + 32'd1;
endfunction

// GHASH over the auth blocks and the length block, then masked with E(J0).
function automatic gcm_pkg::block_t ref_tag(input gcm_pkg::block_t h,
                                            input gcm_pkg::block_t ek_j0,
                                            input gcm_pkg::block_t blks[$],
                                            input int n_aad,
                                            input int n_text);
    gcm_pkg::block_t s;
    gcm_pkg::block_t lens;
    s = '0;
    foreach (blks[i])
    begin
        s = ref_gf_mul(s ^ blks[i], h);
    end
    lens = {64'(n_aad * 128), 64'(n_text * 128)};  // Sizes in bits.
    s = ref_gf_mul(s ^ lens, h);
    return s ^ ek_j0;
endfunction

`endif

// File: tb/gcm_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gcm_core_tb;

    localparam int NUM_INST    = 24;
    localparam int CYCLE_LIMIT = 40 * NUM_INST + 100;

    logic            clk;
    logic            i_arst_n;
    logic            i_new_instance;
    gcm_pkg::iv_t    i_iv;
    gcm_pkg::block_t i_h;
    gcm_pkg::block_t i_ek_j0;
    gcm_pkg::len_t   i_aad_size;
    gcm_pkg::len_t   i_pt_size;
    logic            i_blk_valid;
    gcm_pkg::block_t i_blk_data;
    gcm_pkg::block_t i_keystream;
    gcm_pkg::block_t o_cb;
    logic            o_ct_valid;
    gcm_pkg::block_t o_cipher_text;
    gcm_pkg::block_t o_tag;
    logic            o_tag_ready;

    int errors       = 0;
    int cycles       = 0;
    int ct_checked   = 0;
    int tags_checked = 0;
    gcm_pkg::block_t exp_ct_q[$];
    gcm_pkg::block_t exp_tag_q[$];
    gcm_pkg::block_t data_q[$];   // Blocks of the next instance.
    gcm_pkg::block_t ks_q[$];

    `include "gcm_ref.svh"

    gcm_core
    #(
        .CNT_W (16)
    )
    gcm_core_inst
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_new_instance (i_new_instance),
        .i_iv           (i_iv),
        .i_h            (i_h),
        .i_ek_j0        (i_ek_j0),
        .i_aad_size     (i_aad_size),
        .i_pt_size      (i_pt_size),
        .i_blk_valid    (i_blk_valid),
        .i_blk_data     (i_blk_data),
        .i_keystream    (i_keystream),
        .o_cb           (o_cb),
        .o_ct_valid     (o_ct_valid),
        .o_cipher_text  (o_cipher_text),
        .o_tag          (o_tag),
        .o_tag_ready    (o_tag_ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_block(input string name, input gcm_pkg::block_t got,
                               input gcm_pkg::block_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic gcm_pkg::block_t rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++)
        begin
            data_q.push_back(rand_block());
            ks_q.push_back(rand_block());
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled.
    always @(negedge clk)
    begin
        if (o_ct_valid)
        begin
            if (exp_ct_q.size() == 0)
            begin
                errors++;
                $display("ERROR: o_ct_valid rose with no ciphertext expected");
            end
            else
            begin
                check_block("o_cipher_text", o_cipher_text, exp_ct_q.pop_front());
                ct_checked++;
            end
        end
        if (o_tag_ready)
        begin
            if (exp_tag_q.size() == 0)
            begin
                errors++;
                $display("ERROR: o_tag_ready rose with no tag expected");
            end
            else
            begin
                check_block("o_tag", o_tag, exp_tag_q.pop_front());
                tags_checked++;
            end
            if (exp_ct_q.size() != 0)
            begin
                errors++;
                $display("ERROR: tag arrived while ciphertexts were still missing");
            end
        end
    end

    // One instance from data_q and ks_q, with up to max_gap idle cycles per block.
    task automatic run_instance(input gcm_pkg::iv_t iv, input gcm_pkg::block_t h,
                                input gcm_pkg::block_t ek_j0, input int n_aad,
                                input int n_text, input int max_gap);
        gcm_pkg::block_t exp_cb;
        gcm_pkg::block_t ct;
        gcm_pkg::block_t auth_q[$];
        logic            is_text;
        i_new_instance = 1'b1;
        i_iv           = iv;
        i_h            = h;
        i_ek_j0        = ek_j0;
        i_aad_size     = gcm_pkg::len_t'(n_aad * 128);
        i_pt_size      = gcm_pkg::len_t'(n_text * 128);
        @(negedge clk);
        i_new_instance = 1'b0;
        exp_cb = {iv, 32'h0000_0002};  // IV || 2.
        check_block("o_cb", o_cb, exp_cb);
        for (int i = 0; i < n_aad + n_text; i++)
        begin
            repeat ($urandom_range(max_gap, 0)) @(negedge clk);
            is_text     = (i >= n_aad);
            i_blk_valid = 1'b1;
            i_blk_data  = data_q[i];
            i_keystream = ks_q[i];
            ct          = data_q[i] ^ ks_q[i];
            if (is_text)
            begin
                exp_ct_q.push_back(ct);
                auth_q.push_back(ct);
                exp_cb = ref_inc32(exp_cb);
            end
            else
            begin
                auth_q.push_back(data_q[i]);
            end
            if (i == n_aad + n_text - 1)
            begin
                exp_tag_q.push_back(ref_tag(h, ek_j0, auth_q, n_aad, n_text));
            end
            @(negedge clk);
            i_blk_valid = 1'b0;
            check_flag("o_ct_valid", o_ct_valid, is_text);  // One cycle after the block.
            check_block("o_cb", o_cb, exp_cb);
        end
        repeat (2) @(negedge clk);
        if (o_tag_ready !== 1'b1)
        begin
            errors++;
            $display("ERROR: no tag pulse two cycles after the last block");
        end
        @(negedge clk);
        check_flag("o_tag_ready", o_tag_ready, 1'b0);
        data_q.delete();
        ks_q.delete();
    endtask

    initial
    begin
        gcm_pkg::iv_t iv;
        int           n_total;
        int           n_aad;
        void'($urandom(97));
        clk            = 1'b0;
        i_arst_n       = 1'b0;
        i_new_instance = 1'b0;
        i_iv           = '0;
        i_h            = '0;
        i_ek_j0        = '0;
        i_aad_size     = '0;
        i_pt_size      = '0;
        i_blk_valid    = 1'b0;
        i_blk_data     = '0;
        i_keystream    = '0;
        repeat (2) @(negedge clk);
        i_arst_n = 1'b1;

        repeat (3)
        begin
            @(negedge clk);
            check_flag("o_ct_valid", o_ct_valid, 1'b0);
            check_flag("o_tag_ready", o_tag_ready, 1'b0);
        end

        // Zero key, zero IV, one zero block.
        data_q.push_back('0);
        ks_q.push_back(128'h0388dace60b6a392f328c2b971b2fe78);
        run_instance('0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
                     128'h58e2fccefa7e3061367f1d57a4e7455a, 0, 1, 0);
        check_block("o_cipher_text", o_cipher_text, 128'h0388dace60b6a392f328c2b971b2fe78);
        check_block("o_tag", o_tag, 128'hab6e47d42cec13bdf53a67b21257bddf);

        fill_random(2);  // AAD only.
        run_instance({$urandom, $urandom, $urandom}, rand_block(), rand_block(), 2, 0, 0);

        fill_random(5);
        run_instance({$urandom, $urandom, $urandom}, rand_block(), rand_block(), 2, 3, 0);

        // Last IV word of all ones stays put under inc32.
        iv = {$urandom, $urandom, 32'hffff_ffff};
        fill_random(3);
        run_instance(iv, rand_block(), rand_block(), 0, 3, 0);

        for (int k = 0; k < 20; k++)
        begin
            n_total = $urandom_range(6, 1);
            n_aad   = $urandom_range(n_total, 0);
            fill_random(n_total);
            run_instance({$urandom, $urandom, $urandom}, rand_block(), rand_block(),
                         n_aad, n_total - n_aad, 3);
        end

        repeat (2) @(negedge clk);
        if (exp_ct_q.size() != 0 || exp_tag_q.size() != 0)
        begin
            errors++;
            $display("ERROR: expected results never appeared on the outputs");
        end
        $display("Summary: %0d errors, %0d ciphertexts and %0d tags compared",
                 errors, ct_checked, tags_checked);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tb
hw/gcm_pkg.sv
hw/gf128_mul.sv
hw/gcm_block_seq.sv
hw/gctr_unit.sv
hw/ghash_accum.sv
hw/gcm_core.sv
tb/gcm_core_tb.sv

// File: Bender.yml
package:
  name: gcm_core

sources:
  - hw/gcm_pkg.sv
  - hw/gf128_mul.sv
  - hw/gcm_block_seq.sv
  - hw/gctr_unit.sv
  - hw/ghash_accum.sv
  - hw/gcm_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/gcm_core_tb.sv
